//--- serial_bus_pkg.sv
// serial bus package with bus widths, split threshold and FSM state encodings
`default_nettype none

package serial_bus_pkg;

	// address width, top bit picks the slave
	localparam int ADDR_W = 12;
	localparam int DATA_W = 8;

	// smallest response delay that frees the bus during the wait
	localparam int SPLIT_MIN = 5;
	// delay counter width, delays up to 15
	localparam int DELAY_W = 4;

	typedef enum logic [1:0] {
		slave_idle,
		slave_wait,
		slave_resp
	} slave_state_t;

	typedef enum logic [2:0] {
		m_idle,
		m_req,
		m_addr,
		m_wait,
		m_rx
	} master_state_t;

endpackage

`default_nettype wire

//--- slave_rx.sv
// slave receiver, shifts in serial address and parallel-line write data after a strobe
`timescale 1ns/1ps
`default_nettype none

module slave_rx
	import serial_bus_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire master_valid,
	input wire read_en,
	input wire write_en,
	input wire rx_address,
	input wire rx_data,
	output logic rx_done,
	output logic rx_read,
	output logic [ADDR_W-1:0] address,
	output logic [DATA_W-1:0] data,
	output logic ready
);

	logic active;
	logic dir_read;
	logic [3:0] bit_cnt;

	// busy from the cycle after the strobe through the done pulse
	assign ready = ~(active | rx_done);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			dir_read <= 1'b0;
			bit_cnt <= '0;
			rx_done <= 1'b0;
			rx_read <= 1'b0;
		end
		else
		begin
			// done and direction are single-cycle pulses
			rx_done <= 1'b0;
			rx_read <= 1'b0;
			if (!active)
			begin
				if (master_valid && (read_en || write_en))
				begin
					active <= 1'b1;
					dir_read <= read_en;
					bit_cnt <= '0;
				end
			end
			else if (master_valid)
			begin
				bit_cnt <= bit_cnt + 4'd1;
				// last address bit, report one cycle later
				if (bit_cnt == 4'(ADDR_W - 1))
				begin
					active <= 1'b0;
					rx_done <= 1'b1;
					rx_read <= dir_read;
				end
			end
		end
	end

	// msb first shift, data only during the first byte of cycles
	always_ff @(posedge clk)
	begin
		if (active && master_valid)
		begin
			address <= {address[ADDR_W-2:0], rx_address};
			if (bit_cnt < 4'(DATA_W))
				data <= {data[DATA_W-2:0], rx_data};
		end
	end

endmodule

`default_nettype wire

//--- slave_tx.sv
// slave transmitter, sends a read byte msb first while the master is ready
`timescale 1ns/1ps
`default_nettype none

module slave_tx
	import serial_bus_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire master_ready,
	input wire [DATA_W-1:0] datain,
	output logic tx_data,
	output logic tx_done,
	output logic ready
);

	localparam int CNT_W = $clog2(DATA_W);

	logic [DATA_W-1:0] shreg;
	logic [CNT_W-1:0] bit_cnt;
	logic pending;
	logic shift;

	// back-pressure just stalls the shift
	assign shift = pending & master_ready;
	assign tx_data = shreg[DATA_W-1];
	// done comes with the last bit on the line
	assign tx_done = shift & (bit_cnt == CNT_W'(DATA_W - 1));
	assign ready = ~pending;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pending <= 1'b0;
			bit_cnt <= '0;
		end
		else if (load)
		begin
			pending <= 1'b1;
			bit_cnt <= '0;
		end
		else if (shift)
		begin
			bit_cnt <= bit_cnt + 1'b1;
			if (tx_done)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= datain;
		else if (shift)
			shreg <= shreg << 1;
	end

endmodule

`default_nettype wire

//--- slave_port.sv
// slave port, receives a transfer, accesses local memory and answers reads after a delay
`timescale 1ns/1ps
`default_nettype none

module slave_port
	import serial_bus_pkg::*;
#(
	parameter int SLAVE_DELAY = 2
) (
	input wire clk,
	input wire rst_n,
	input wire read_en,
	input wire write_en,
	input wire master_valid,
	input wire master_ready,
	input wire rx_address,
	input wire rx_data,
	output logic slave_valid,
	output logic slave_ready,
	output logic tx_data,
	output logic tx_done,
	output logic split_en,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	output logic mem_we,
	input wire [DATA_W-1:0] mem_rdata
);

	slave_state_t state;
	logic [DELAY_W-1:0] delay_cnt;
	logic rx_done;
	logic rx_read;
	logic rx_ready;
	logic tx_ready;
	logic tx_load;

	slave_rx u_rx (
		.clk(clk), .rst_n(rst_n),
		.master_valid(master_valid), .read_en(read_en), .write_en(write_en),
		.rx_address(rx_address), .rx_data(rx_data),
		.rx_done(rx_done), .rx_read(rx_read),
		.address(mem_addr), .data(mem_wdata), .ready(rx_ready)
	);

	slave_tx u_tx (
		.clk(clk), .rst_n(rst_n),
		.load(tx_load), .master_ready(master_ready), .datain(mem_rdata),
		.tx_data(tx_data), .tx_done(tx_done), .ready(tx_ready)
	);

	// write lands on the done pulse, address and data still held
	assign mem_we = rx_done & ~rx_read;
	// last wait cycle, memory read is combinational so load here
	assign tx_load = (state == slave_wait) && (delay_cnt == DELAY_W'(SLAVE_DELAY - 1));
	assign slave_valid = (state == slave_resp);
	// long delays let the arbiter hand the bus to the other master
	assign split_en = (state == slave_wait) && (SLAVE_DELAY >= SPLIT_MIN);
	assign slave_ready = rx_ready & tx_ready & (state == slave_idle);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= slave_idle;
			delay_cnt <= '0;
		end
		else
		begin
			case (state)
				slave_idle:
				begin
					if (rx_done && rx_read)
					begin
						state <= slave_wait;
						delay_cnt <= '0;
					end
				end
				slave_wait:
				begin
					if (tx_load)
						state <= slave_resp;
					else
						delay_cnt <= delay_cnt + 1'b1;
				end
				slave_resp:
				begin
					// valid drops the cycle after the last bit
					if (tx_done)
						state <= slave_idle;
				end
				default: state <= slave_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- slave_mem.sv
// slave memory, synchronous write and asynchronous read of a small byte array
`timescale 1ns/1ps
`default_nettype none

module slave_mem
	import serial_bus_pkg::*;
#(
	parameter int MEM_AW = 6
) (
	input wire clk,
	input wire mem_we,
	input wire [ADDR_W-1:0] mem_addr,
	input wire [DATA_W-1:0] mem_wdata,
	output logic [DATA_W-1:0] mem_rdata
);

	logic [DATA_W-1:0] mem [2**MEM_AW];

	// only the low address bits index the array
	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[mem_addr[MEM_AW-1:0]] <= mem_wdata;
	end

	assign mem_rdata = mem[mem_addr[MEM_AW-1:0]];

endmodule

`default_nettype wire

//--- master_port.sv
// master port, requests the bus, serializes a command and collects the read reply
`timescale 1ns/1ps
`default_nettype none

module master_port
	import serial_bus_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire cmd_start,
	input wire cmd_write,
	input wire [ADDR_W-1:0] cmd_addr,
	input wire [DATA_W-1:0] cmd_wdata,
	output logic busy,
	output logic [DATA_W-1:0] rdata,
	output logic rdata_valid,
	output logic req,
	output logic sel,
	output logic read_en,
	output logic write_en,
	output logic master_valid,
	output logic addr_bit,
	output logic data_bit,
	output logic master_ready,
	input wire gnt,
	input wire ready,
	input wire slave_valid,
	input wire tx_bit,
	input wire tx_done
);

	master_state_t state;
	logic wr;
	// final busy cycle of a transaction
	logic done;
	logic launch;
	logic [3:0] bit_cnt;
	logic [ADDR_W-1:0] addr_sh;
	logic [DATA_W-1:0] data_sh;

	// strobe on the first cycle with grant and slave ready
	assign launch = (state == m_req) && gnt && ready;
	assign busy = (state != m_idle);
	assign req = (state == m_req) || (state == m_addr);
	assign read_en = launch & ~wr;
	assign write_en = launch & wr;
	assign master_valid = launch || (state == m_addr);
	assign addr_bit = addr_sh[ADDR_W-1];
	assign data_bit = data_sh[DATA_W-1];
	assign master_ready = (state == m_rx) && !done;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= m_idle;
			wr <= 1'b0;
			sel <= 1'b0;
			done <= 1'b0;
			bit_cnt <= '0;
			rdata_valid <= 1'b0;
		end
		else
		begin
			rdata_valid <= 1'b0;
			case (state)
				m_idle:
				begin
					// new commands only while idle
					if (cmd_start)
					begin
						state <= m_req;
						wr <= cmd_write;
						sel <= cmd_addr[ADDR_W-1];
					end
				end
				m_req:
				begin
					if (launch)
					begin
						state <= m_addr;
						bit_cnt <= '0;
					end
				end
				m_addr:
				begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'(ADDR_W - 1))
					begin
						state <= m_wait;
						// a write is finished here
						done <= wr;
					end
				end
				m_wait:
				begin
					// split or not, a read just waits for valid
					if (done)
					begin
						state <= m_idle;
						done <= 1'b0;
					end
					else if (slave_valid)
						state <= m_rx;
				end
				m_rx:
				begin
					if (done)
					begin
						state <= m_idle;
						done <= 1'b0;
					end
					else if (tx_done)
					begin
						done <= 1'b1;
						rdata_valid <= 1'b1;
					end
				end
				default: state <= m_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == m_idle && cmd_start)
		begin
			addr_sh <= cmd_addr;
			data_sh <= cmd_wdata;
		end
		else if (state == m_addr)
		begin
			addr_sh <= addr_sh << 1;
			data_sh <= data_sh << 1;
		end
		// reply bits arrive msb first
		if (master_ready)
			rdata <= {rdata[DATA_W-2:0], tx_bit};
	end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
// bus arbiter, round-robin grant of the request lines and response steering per slave
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input wire clk,
	input wire rst_n,
	input wire m0_req, m0_sel, m0_read_en, m0_write_en,
	input wire m0_master_valid, m0_addr_bit, m0_data_bit, m0_master_ready,
	input wire m1_req, m1_sel, m1_read_en, m1_write_en,
	input wire m1_master_valid, m1_addr_bit, m1_data_bit, m1_master_ready,
	input wire s0_slave_valid, s0_slave_ready, s0_tx_data, s0_tx_done, s0_split_en,
	input wire s1_slave_valid, s1_slave_ready, s1_tx_data, s1_tx_done, s1_split_en,
	output logic m0_gnt, m0_ready, m0_slave_valid, m0_tx_bit, m0_tx_done,
	output logic m1_gnt, m1_ready, m1_slave_valid, m1_tx_bit, m1_tx_done,
	output logic s0_read_en, s0_write_en, s0_master_valid, s0_master_ready,
	output logic s1_read_en, s1_write_en, s1_master_valid, s1_master_ready,
	output logic rx_address,
	output logic rx_data
);

	logic bus_held;
	// current or most recent grant holder
	logic owner;
	logic hold;
	logic pick;
	logic own_sel, own_read, own_write, own_valid;
	// which master each slave answers
	logic [1:0] slave_owner;

	// granted master onto the shared request lines
	assign own_sel = owner ? m1_sel : m0_sel;
	assign own_read = bus_held & (owner ? m1_read_en : m0_read_en);
	assign own_write = bus_held & (owner ? m1_write_en : m0_write_en);
	assign own_valid = bus_held & (owner ? m1_master_valid : m0_master_valid);
	assign rx_address = owner ? m1_addr_bit : m0_addr_bit;
	assign rx_data = owner ? m1_data_bit : m0_data_bit;

	// strobes only reach the selected slave
	assign s0_read_en = own_read & ~own_sel;
	assign s1_read_en = own_read & own_sel;
	assign s0_write_en = own_write & ~own_sel;
	assign s1_write_en = own_write & own_sel;
	assign s0_master_valid = own_valid & ~own_sel;
	assign s1_master_valid = own_valid & own_sel;

	assign m0_gnt = bus_held & ~owner;
	assign m1_gnt = bus_held & owner;

	// keep the bus while requesting, or while the target is busy and not splitting
	assign hold = (owner ? m1_req : m0_req)
		| (own_sel ? (~s1_slave_ready & ~s1_split_en) : (~s0_slave_ready & ~s0_split_en));
	// on a tie the master not granted last wins
	assign pick = (m0_req & m1_req) ? ~owner : m1_req;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bus_held <= 1'b0;
			// master 0 wins the first tie
			owner <= 1'b1;
			slave_owner <= '0;
		end
		else
		begin
			if (!(bus_held && hold))
			begin
				bus_held <= m0_req | m1_req;
				if (m0_req | m1_req)
					owner <= pick;
			end
			// owner recorded at the strobe
			if (own_read | own_write)
				slave_owner[own_sel] <= owner;
		end
	end

	// responses go back to the recorded owner only
	assign m0_ready = m0_sel ? s1_slave_ready : s0_slave_ready;
	assign m1_ready = m1_sel ? s1_slave_ready : s0_slave_ready;
	assign m0_tx_bit = m0_sel ? s1_tx_data : s0_tx_data;
	assign m1_tx_bit = m1_sel ? s1_tx_data : s0_tx_data;
	assign m0_slave_valid = m0_sel ? (s1_slave_valid & ~slave_owner[1])
		: (s0_slave_valid & ~slave_owner[0]);
	assign m1_slave_valid = m1_sel ? (s1_slave_valid & slave_owner[1])
		: (s0_slave_valid & slave_owner[0]);
	assign m0_tx_done = m0_sel ? (s1_tx_done & ~slave_owner[1]) : (s0_tx_done & ~slave_owner[0]);
	assign m1_tx_done = m1_sel ? (s1_tx_done & slave_owner[1]) : (s0_tx_done & slave_owner[0]);
	assign s0_master_ready = slave_owner[0] ? m1_master_ready : m0_master_ready;
	assign s1_master_ready = slave_owner[1] ? m1_master_ready : m0_master_ready;

endmodule

`default_nettype wire

//--- serial_bus_top.sv
// serial bus top, two masters and two memory-backed slaves behind one arbiter
`timescale 1ns/1ps
`default_nettype none

module serial_bus_top
	import serial_bus_pkg::*;
#(
	parameter int SLAVE_DELAY_0 = 2,
	parameter int SLAVE_DELAY_1 = 8,
	parameter int MEM_AW = 6
) (
	input wire clk,
	input wire rst_n,
	input wire cmd_start_0,
	input wire cmd_write_0,
	input wire [ADDR_W-1:0] cmd_addr_0,
	input wire [DATA_W-1:0] cmd_wdata_0,
	output wire busy_0,
	output wire [DATA_W-1:0] rdata_0,
	output wire rdata_valid_0,
	input wire cmd_start_1,
	input wire cmd_write_1,
	input wire [ADDR_W-1:0] cmd_addr_1,
	input wire [DATA_W-1:0] cmd_wdata_1,
	output wire busy_1,
	output wire [DATA_W-1:0] rdata_1,
	output wire rdata_valid_1
);

	// master side of the arbiter
	wire m0_req, m0_sel, m0_read_en, m0_write_en, m0_master_valid;
	wire m0_addr_bit, m0_data_bit, m0_master_ready;
	wire m0_gnt, m0_ready, m0_slave_valid, m0_tx_bit, m0_tx_done;
	wire m1_req, m1_sel, m1_read_en, m1_write_en, m1_master_valid;
	wire m1_addr_bit, m1_data_bit, m1_master_ready;
	wire m1_gnt, m1_ready, m1_slave_valid, m1_tx_bit, m1_tx_done;
	// slave side, address and data lines shared
	wire rx_address, rx_data;
	wire s0_read_en, s0_write_en, s0_master_valid, s0_master_ready;
	wire s0_slave_valid, s0_slave_ready, s0_tx_data, s0_tx_done, s0_split_en;
	wire s1_read_en, s1_write_en, s1_master_valid, s1_master_ready;
	wire s1_slave_valid, s1_slave_ready, s1_tx_data, s1_tx_done, s1_split_en;
	// memory buses
	wire [ADDR_W-1:0] s0_mem_addr, s1_mem_addr;
	wire [DATA_W-1:0] s0_mem_wdata, s1_mem_wdata, s0_mem_rdata, s1_mem_rdata;
	wire s0_mem_we, s1_mem_we;

	master_port u_master_0 (
		.clk(clk), .rst_n(rst_n), .cmd_start(cmd_start_0), .cmd_write(cmd_write_0),
		.cmd_addr(cmd_addr_0), .cmd_wdata(cmd_wdata_0),
		.busy(busy_0), .rdata(rdata_0), .rdata_valid(rdata_valid_0),
		.req(m0_req), .sel(m0_sel), .read_en(m0_read_en), .write_en(m0_write_en),
		.master_valid(m0_master_valid), .addr_bit(m0_addr_bit), .data_bit(m0_data_bit),
		.master_ready(m0_master_ready), .gnt(m0_gnt), .ready(m0_ready),
		.slave_valid(m0_slave_valid), .tx_bit(m0_tx_bit), .tx_done(m0_tx_done)
	);

	master_port u_master_1 (
		.clk(clk), .rst_n(rst_n), .cmd_start(cmd_start_1), .cmd_write(cmd_write_1),
		.cmd_addr(cmd_addr_1), .cmd_wdata(cmd_wdata_1),
		.busy(busy_1), .rdata(rdata_1), .rdata_valid(rdata_valid_1),
		.req(m1_req), .sel(m1_sel), .read_en(m1_read_en), .write_en(m1_write_en),
		.master_valid(m1_master_valid), .addr_bit(m1_addr_bit), .data_bit(m1_data_bit),
		.master_ready(m1_master_ready), .gnt(m1_gnt), .ready(m1_ready),
		.slave_valid(m1_slave_valid), .tx_bit(m1_tx_bit), .tx_done(m1_tx_done)
	);

	bus_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n),
		.m0_req(m0_req), .m0_sel(m0_sel), .m0_read_en(m0_read_en),
		.m0_write_en(m0_write_en), .m0_master_valid(m0_master_valid),
		.m0_addr_bit(m0_addr_bit), .m0_data_bit(m0_data_bit),
		.m0_master_ready(m0_master_ready),
		.m1_req(m1_req), .m1_sel(m1_sel), .m1_read_en(m1_read_en),
		.m1_write_en(m1_write_en), .m1_master_valid(m1_master_valid),
		.m1_addr_bit(m1_addr_bit), .m1_data_bit(m1_data_bit),
		.m1_master_ready(m1_master_ready),
		.s0_slave_valid(s0_slave_valid), .s0_slave_ready(s0_slave_ready),
		.s0_tx_data(s0_tx_data), .s0_tx_done(s0_tx_done), .s0_split_en(s0_split_en),
		.s1_slave_valid(s1_slave_valid), .s1_slave_ready(s1_slave_ready),
		.s1_tx_data(s1_tx_data), .s1_tx_done(s1_tx_done), .s1_split_en(s1_split_en),
		.m0_gnt(m0_gnt), .m0_ready(m0_ready), .m0_slave_valid(m0_slave_valid),
		.m0_tx_bit(m0_tx_bit), .m0_tx_done(m0_tx_done),
		.m1_gnt(m1_gnt), .m1_ready(m1_ready), .m1_slave_valid(m1_slave_valid),
		.m1_tx_bit(m1_tx_bit), .m1_tx_done(m1_tx_done),
		.s0_read_en(s0_read_en), .s0_write_en(s0_write_en),
		.s0_master_valid(s0_master_valid), .s0_master_ready(s0_master_ready),
		.s1_read_en(s1_read_en), .s1_write_en(s1_write_en),
		.s1_master_valid(s1_master_valid), .s1_master_ready(s1_master_ready),
		.rx_address(rx_address), .rx_data(rx_data)
	);

	slave_port #(.SLAVE_DELAY(SLAVE_DELAY_0)) u_slave_0 (
		.clk(clk), .rst_n(rst_n), .read_en(s0_read_en), .write_en(s0_write_en),
		.master_valid(s0_master_valid), .master_ready(s0_master_ready),
		.rx_address(rx_address), .rx_data(rx_data),
		.slave_valid(s0_slave_valid), .slave_ready(s0_slave_ready), .tx_data(s0_tx_data),
		.tx_done(s0_tx_done), .split_en(s0_split_en),
		.mem_addr(s0_mem_addr), .mem_wdata(s0_mem_wdata), .mem_we(s0_mem_we),
		.mem_rdata(s0_mem_rdata)
	);

	slave_port #(.SLAVE_DELAY(SLAVE_DELAY_1)) u_slave_1 (
		.clk(clk), .rst_n(rst_n), .read_en(s1_read_en), .write_en(s1_write_en),
		.master_valid(s1_master_valid), .master_ready(s1_master_ready),
		.rx_address(rx_address), .rx_data(rx_data),
		.slave_valid(s1_slave_valid), .slave_ready(s1_slave_ready), .tx_data(s1_tx_data),
		.tx_done(s1_tx_done), .split_en(s1_split_en),
		.mem_addr(s1_mem_addr), .mem_wdata(s1_mem_wdata), .mem_we(s1_mem_we),
		.mem_rdata(s1_mem_rdata)
	);

	slave_mem #(.MEM_AW(MEM_AW)) u_mem_0 (
		.clk(clk), .mem_we(s0_mem_we), .mem_addr(s0_mem_addr),
		.mem_wdata(s0_mem_wdata), .mem_rdata(s0_mem_rdata)
	);

	slave_mem #(.MEM_AW(MEM_AW)) u_mem_1 (
		.clk(clk), .mem_we(s1_mem_we), .mem_addr(s1_mem_addr),
		.mem_wdata(s1_mem_wdata), .mem_rdata(s1_mem_rdata)
	);

endmodule

`default_nettype wire

//--- serial_bus_chk.sv
// protocol checker on the command side of the serial bus, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module serial_bus_chk (
	input wire clk,
	input wire rst_n,
	input wire busy_0,
	input wire rdata_valid_0,
	input wire busy_1,
	input wire rdata_valid_1
);

	// failed assertions so far
	int fail_count = 0;

	// quiet in the cycle after a reset cycle
	idle_after_reset_0: assert property (@(posedge clk) !rst_n |=> !busy_0 && !rdata_valid_0)
	else
	begin
		fail_count++;
		$error("master 0 busy or rdata_valid high after reset");
	end
	idle_after_reset_1: assert property (@(posedge clk) !rst_n |=> !busy_1 && !rdata_valid_1)
	else
	begin
		fail_count++;
		$error("master 1 busy or rdata_valid high after reset");
	end

	// read data only inside a transfer
	valid_in_busy_0: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid_0 |-> busy_0)
	else
	begin
		fail_count++;
		$error("master 0 rdata_valid while not busy");
	end
	valid_in_busy_1: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid_1 |-> busy_1)
	else
	begin
		fail_count++;
		$error("master 1 rdata_valid while not busy");
	end

	// single-cycle pulse, transfer over on the next cycle
	valid_pulse_0: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid_0 |=> !rdata_valid_0 && !busy_0)
	else
	begin
		fail_count++;
		$error("master 0 rdata_valid longer than one cycle or busy still high");
	end
	valid_pulse_1: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid_1 |=> !rdata_valid_1 && !busy_1)
	else
	begin
		fail_count++;
		$error("master 1 rdata_valid longer than one cycle or busy still high");
	end

endmodule

bind serial_bus_top serial_bus_chk chk_i (
	.clk(clk),
	.rst_n(rst_n),
	.busy_0(busy_0),
	.rdata_valid_0(rdata_valid_0),
	.busy_1(busy_1),
	.rdata_valid_1(rdata_valid_1)
);

`default_nettype wire

//--- serial_bus_tb.sv
// serial bus testbench, directed and random transfers checked against a reference memory
`timescale 1ns/1ps
`default_nettype none

module serial_bus_tb
	import serial_bus_pkg::*;
();

	localparam int MEM_AW = 6;
	// random write and read-back pairs
	localparam int RAND_PAIRS = 8;
	// all transfers of the run including the ignored command
	localparam int NUM_TXN = 30;
	// worst case per transfer with the other master in front
	localparam int TXN_MAX_CYCLES = 80;
	localparam int TIMEOUT_CYCLES = NUM_TXN * TXN_MAX_CYCLES;

	logic clk;
	logic rst_n;
	logic cmd_start_0;
	logic cmd_write_0;
	logic [ADDR_W-1:0] cmd_addr_0;
	logic [DATA_W-1:0] cmd_wdata_0;
	logic busy_0;
	logic [DATA_W-1:0] rdata_0;
	logic rdata_valid_0;
	logic cmd_start_1;
	logic cmd_write_1;
	logic [ADDR_W-1:0] cmd_addr_1;
	logic [DATA_W-1:0] cmd_wdata_1;
	logic busy_1;
	logic [DATA_W-1:0] rdata_1;
	logic rdata_valid_1;

	// reference copy of both slave memories
	logic [DATA_W-1:0] ref_mem [2][2**MEM_AW];
	// expected read bytes per master in issue order
	logic [DATA_W-1:0] exp_q0 [$];
	logic [DATA_W-1:0] exp_q1 [$];

	int seed = 32'h2180;
	int cycle_cnt = 0;
	int accepted_0 = 0;
	int accepted_1 = 0;
	int done_0 = 0;
	int done_1 = 0;
	int done_cyc_0 = 0;
	int done_cyc_1 = 0;
	int rv_cyc_0 = 0;
	int data_errors = 0;
	int order_errors = 0;
	int count_errors = 0;
	logic busy_q0 = 1'b0;
	logic busy_q1 = 1'b0;

	serial_bus_top #(
		.SLAVE_DELAY_0(2),
		.SLAVE_DELAY_1(8),
		.MEM_AW(MEM_AW)
	) dut_i (
		.clk(clk), .rst_n(rst_n),
		.cmd_start_0(cmd_start_0), .cmd_write_0(cmd_write_0),
		.cmd_addr_0(cmd_addr_0), .cmd_wdata_0(cmd_wdata_0),
		.busy_0(busy_0), .rdata_0(rdata_0), .rdata_valid_0(rdata_valid_0),
		.cmd_start_1(cmd_start_1), .cmd_write_1(cmd_write_1),
		.cmd_addr_1(cmd_addr_1), .cmd_wdata_1(cmd_wdata_1),
		.busy_1(busy_1), .rdata_1(rdata_1), .rdata_valid_1(rdata_valid_1)
	);

	always #20 clk = ~clk;

	function automatic logic [DATA_W-1:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[DATA_W-1:0];
	endfunction

	// top bit picks the slave and low bits index its memory
	function automatic logic [ADDR_W-1:0] rand_addr(input logic slave);
		logic [31:0] r;
		r = $random(seed);
		return {slave, {(ADDR_W-1-MEM_AW){1'b0}}, r[MEM_AW-1:0]};
	endfunction

	// drive one command and book it in the reference model
	task automatic load_cmd(input int m, input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		if (wr)
			ref_mem[addr[ADDR_W-1]][addr[MEM_AW-1:0]] = data;
		else if (m == 0)
			exp_q0.push_back(ref_mem[addr[ADDR_W-1]][addr[MEM_AW-1:0]]);
		else
			exp_q1.push_back(ref_mem[addr[ADDR_W-1]][addr[MEM_AW-1:0]]);
		if (m == 0)
		begin
			cmd_start_0 <= 1'b1;
			cmd_write_0 <= wr;
			cmd_addr_0 <= addr;
			cmd_wdata_0 <= data;
		end
		else
		begin
			cmd_start_1 <= 1'b1;
			cmd_write_1 <= wr;
			cmd_addr_1 <= addr;
			cmd_wdata_1 <= data;
		end
	endtask

	task automatic issue_cmd(input int m, input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		@(posedge clk);
		load_cmd(m, wr, addr, data);
		@(posedge clk);
		cmd_start_0 <= 1'b0;
		cmd_start_1 <= 1'b0;
	endtask

	// both masters write in the same cycle
	task automatic issue_pair(input logic [ADDR_W-1:0] addr0, input logic [DATA_W-1:0] data0,
		input logic [ADDR_W-1:0] addr1, input logic [DATA_W-1:0] data1);
		@(posedge clk);
		load_cmd(0, 1'b1, addr0, data0);
		load_cmd(1, 1'b1, addr1, data1);
		@(posedge clk);
		cmd_start_0 <= 1'b0;
		cmd_start_1 <= 1'b0;
	endtask

	// start pulse on master 0 that must be dropped without touching the reference
	task automatic present_while_busy(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		@(posedge clk);
		cmd_start_0 <= 1'b1;
		cmd_write_0 <= 1'b1;
		cmd_addr_0 <= addr;
		cmd_wdata_0 <= data;
		@(negedge clk);
		assert (busy_0)
		else
		begin
			count_errors++;
			$display("error t=%0t master 0 was idle when the extra command came", $time);
		end
		@(posedge clk);
		cmd_start_0 <= 1'b0;
	endtask

	task automatic wait_idle(input int m);
		@(negedge clk);
		while ((m == 0) ? busy_0 : busy_1)
			@(negedge clk);
	endtask

	task automatic wait_all_idle();
		@(negedge clk);
		while (busy_0 || busy_1)
			@(negedge clk);
	endtask

	task automatic check_read(input int m, input logic [DATA_W-1:0] got);
		logic [DATA_W-1:0] exp;
		int left;
		left = (m == 0) ? exp_q0.size() : exp_q1.size();
		assert (left > 0)
		else
		begin
			data_errors++;
			$display("error t=%0t master %0d returned data with no read pending", $time, m);
		end
		if (left > 0)
		begin
			if (m == 0)
				exp = exp_q0.pop_front();
			else
				exp = exp_q1.pop_front();
			assert (got == exp)
			else
			begin
				data_errors++;
				$display("error t=%0t rdata_%0d expected %02h got %02h", $time, m, exp, got);
			end
		end
	endtask

	task automatic finish_run(input logic timed_out);
		int chk_errors;
		chk_errors = dut_i.chk_i.fail_count;
		$display("errors: data %0d, order %0d, count %0d, assertion %0d, timeout %0d",
			data_errors, order_errors, count_errors, chk_errors, timed_out);
		if (timed_out || (data_errors + order_errors + count_errors + chk_errors) != 0)
			$display("TEST FAILED");
		else
			$display("TEST OK");
		$finish;
	endtask

	// outputs settle between edges so sample on the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (cmd_start_0 && !busy_0)
				accepted_0++;
			if (cmd_start_1 && !busy_1)
				accepted_1++;
			if (busy_q0 && !busy_0)
			begin
				done_0++;
				done_cyc_0 = cycle_cnt;
			end
			if (busy_q1 && !busy_1)
			begin
				done_1++;
				done_cyc_1 = cycle_cnt;
			end
			if (rdata_valid_0)
			begin
				rv_cyc_0 = cycle_cnt;
				check_read(0, rdata_0);
			end
			if (rdata_valid_1)
				check_read(1, rdata_1);
		end
		busy_q0 = busy_0;
		busy_q1 = busy_1;
	end

	// watchdog
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the transfers did not finish", cycle_cnt);
			finish_run(1'b1);
		end
	end

	initial
	begin
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;
		logic [DATA_W-1:0] s;
		int m;
		int write_done_cyc;
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_start_0 = 1'b0;
		cmd_write_0 = 1'b0;
		cmd_addr_0 = '0;
		cmd_wdata_0 = '0;
		cmd_start_1 = 1'b0;
		cmd_write_1 = 1'b0;
		cmd_addr_1 = '0;
		cmd_wdata_1 = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// tie right after reset goes to master 0
		a = rand_addr(1'b0);
		b = a ^ 12'h001;
		issue_pair(a, rand_byte(), b, rand_byte());
		wait_all_idle();
		@(posedge clk);
		assert (done_cyc_0 < done_cyc_1)
		else
		begin
			order_errors++;
			$display("error t=%0t master 0 did not finish first in the first tie", $time);
		end
		// cross read-back leaves master 0 as the last grant holder
		issue_cmd(1, 1'b0, a, 8'h00);
		wait_idle(1);
		issue_cmd(0, 1'b0, b, 8'h00);
		wait_idle(0);
		// second tie goes to master 1
		a = rand_addr(1'b0);
		b = a ^ 12'h001;
		issue_pair(a, rand_byte(), b, rand_byte());
		wait_all_idle();
		@(posedge clk);
		assert (done_cyc_1 < done_cyc_0)
		else
		begin
			order_errors++;
			$display("error t=%0t master 1 did not finish first in the second tie", $time);
		end
		issue_cmd(1, 1'b0, a, 8'h00);
		wait_idle(1);
		issue_cmd(0, 1'b0, b, 8'h00);
		wait_idle(0);

		// random writes read back by the other master
		for (int i = 0; i < RAND_PAIRS; i++)
		begin
			s = rand_byte();
			a = rand_addr(s[0]);
			m = i % 2;
			issue_cmd(m, 1'b1, a, rand_byte());
			wait_idle(m);
			issue_cmd(1 - m, 1'b0, a, 8'h00);
			wait_idle(1 - m);
		end

		// master 1 writes slave 0 while slave 1 prepares master 0's split read
		a = rand_addr(1'b1);
		b = rand_addr(1'b0);
		issue_cmd(1, 1'b1, a, rand_byte());
		wait_idle(1);
		@(posedge clk);
		rv_cyc_0 = 0;
		issue_cmd(0, 1'b0, a, 8'h00);
		repeat (2) @(posedge clk);
		issue_cmd(1, 1'b1, b, rand_byte());
		wait_idle(1);
		@(posedge clk);
		write_done_cyc = done_cyc_1;
		issue_cmd(1, 1'b0, b, 8'h00);
		wait_all_idle();
		@(posedge clk);
		assert (write_done_cyc < rv_cyc_0)
		else
		begin
			order_errors++;
			$display("error t=%0t master 1 write did not overlap the split read", $time);
		end

		// extra start in the middle of a long read on slave 1
		issue_cmd(0, 1'b0, a, 8'h00);
		repeat (3) @(posedge clk);
		present_while_busy(b ^ 12'h002, rand_byte());
		wait_idle(0);
		// a dropped start would come back here as a late extra transfer
		repeat (2) @(posedge clk);
		wait_idle(0);
		@(posedge clk);

		assert (done_0 == accepted_0)
		else
		begin
			count_errors++;
			$display("error t=%0t done_0 expected %0d got %0d", $time, accepted_0, done_0);
		end
		assert (done_1 == accepted_1)
		else
		begin
			count_errors++;
			$display("error t=%0t done_1 expected %0d got %0d", $time, accepted_1, done_1);
		end
		assert (exp_q0.size() == 0 && exp_q1.size() == 0)
		else
		begin
			data_errors++;
			$display("error t=%0t reads still pending at the end of the run", $time);
		end
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

//--- flist.f
serial_bus_pkg.sv
slave_rx.sv
slave_tx.sv
slave_port.sv
slave_mem.sv
master_port.sv
bus_arbiter.sv
serial_bus_top.sv
serial_bus_chk.sv
serial_bus_tb.sv

//--- Makefile
# Verilator build and run of the serial bus testbench

VERILATOR ?= verilator
TOP ?= serial_bus_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000

SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_EXE): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_EXE)
	$(SIM_EXE) $(RUN_ARGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
